//--- design/attn_pkg.sv
package attn_pkg;

  // Head and block geometry
  localparam int NUM_HEADS = 4;
  localparam int LANES = 4;
  localparam int ELEM_W = 8;
  localparam int BLOCK_W = LANES * ELEM_W;

  // Largest programmable head length, in blocks
  localparam int MAX_BLOCK_PER_HEAD = 8;

  // Holds 1 to MAX_BLOCK_PER_HEAD inclusive, so one bit above the count width
  localparam int BPH_W = $clog2(MAX_BLOCK_PER_HEAD) + 1;

  localparam int HEAD_W = $clog2(NUM_HEADS);

  // Full product of two signed elements
  localparam int PROD_W = 2 * ELEM_W;

  // Sum of all lane products in one block
  localparam int LANE_SUM_W = PROD_W + $clog2(LANES);

  // Worst case sum over a full head never overflows
  localparam int SCORE_W = PROD_W + $clog2(LANES * MAX_BLOCK_PER_HEAD);

endpackage

//--- design/head_dot_unit.sv
module head_dot_unit (
  input  logic                                clk,
  input  logic                                rst,

  input  logic [attn_pkg::BPH_W-1:0]          block_per_head,

  input  logic                                query_valid,
  output logic                                query_ready,
  input  logic [attn_pkg::BLOCK_W-1:0]        query_data,

  input  logic                                key_valid,
  output logic                                key_ready,
  input  logic [attn_pkg::BLOCK_W-1:0]        key_data,

  output logic                                score_valid,
  input  logic                                score_ready,
  output logic signed [attn_pkg::SCORE_W-1:0] score
);

  import attn_pkg::*;

  logic signed [ELEM_W-1:0]     q_lane [LANES];
  logic signed [ELEM_W-1:0]     k_lane [LANES];
  logic signed [PROD_W-1:0]     prod [LANES];
  logic signed [LANE_SUM_W-1:0] lane_sum;

  logic signed [SCORE_W-1:0]    acc;
  logic signed [SCORE_W-1:0]    acc_next;
  logic [BPH_W-1:0]             pair_cnt;

  logic pair_fire;
  logic last_pair;

  // Lane 0 sits in the low byte
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      q_lane[i] = query_data[i*ELEM_W +: ELEM_W];
      k_lane[i] = key_data[i*ELEM_W +: ELEM_W];
      prod[i]   = q_lane[i] * k_lane[i];
    end
  end

  always_comb begin
    lane_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      lane_sum = lane_sum + prod[i];
    end
  end

  assign acc_next = acc + lane_sum;

  // A pair moves only when both halves are present and the score slot is free
  assign query_ready = key_valid && !score_valid;
  assign key_ready   = query_valid && !score_valid;
  assign pair_fire   = query_valid && key_valid && !score_valid;

  assign last_pair = (pair_cnt == block_per_head - 1'b1);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc      <= '0;
      pair_cnt <= '0;
    end else if (pair_fire) begin
      if (last_pair) begin
        acc      <= '0;
        pair_cnt <= '0;
      end else begin
        acc      <= acc_next;
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      score_valid <= 1'b0;
    end else if (pair_fire && last_pair) begin
      score_valid <= 1'b1;
    end else if (score_ready) begin
      score_valid <= 1'b0;
    end
  end

  // Held until the gather takes it
  always_ff @(posedge clk) begin
    if (pair_fire && last_pair) begin
      score <= acc_next;
    end
  end

  // Nothing builds up toward the next head while a score waits
  a_no_pair_while_pending: assert property (
    @(posedge clk) disable iff (rst)
    score_valid |-> (pair_cnt == '0 && acc == '0)
  );

  // Finished score must survive until it is taken
  a_score_held: assert property (
    @(posedge clk) disable iff (rst)
    (score_valid && !score_ready) |=> (score_valid && $stable(score))
  );

endmodule

//--- design/head_scatter.sv
module head_scatter (
  input  logic                            clk,
  input  logic                            rst,

  input  logic [attn_pkg::BPH_W-1:0]      block_per_head,

  input  logic                            query_valid,
  output logic                            query_ready,

  input  logic                            key_valid,
  output logic                            key_ready,

  output logic [attn_pkg::NUM_HEADS-1:0]  split_query_valid,
  input  logic [attn_pkg::NUM_HEADS-1:0]  split_query_ready,

  output logic [attn_pkg::NUM_HEADS-1:0]  split_key_valid,
  input  logic [attn_pkg::NUM_HEADS-1:0]  split_key_ready
);

  import attn_pkg::*;

  logic [BPH_W-1:0]  query_block_cnt;
  logic [BPH_W-1:0]  key_block_cnt;
  logic [HEAD_W-1:0] query_head_cnt;
  logic [HEAD_W-1:0] key_head_cnt;

  logic query_fire;
  logic key_fire;
  logic query_last_block;
  logic key_last_block;

  assign query_fire = query_valid && query_ready;
  assign key_fire   = key_valid && key_ready;

  assign query_last_block = (query_block_cnt == block_per_head - 1'b1);
  assign key_last_block   = (key_block_cnt == block_per_head - 1'b1);

  // Query stream position
  always_ff @(posedge clk) begin
    if (rst) begin
      query_block_cnt <= '0;
      query_head_cnt  <= '0;
    end else if (query_fire) begin
      if (query_last_block) begin
        query_block_cnt <= '0;
        if (query_head_cnt == HEAD_W'(NUM_HEADS - 1)) begin
          query_head_cnt <= '0;
        end else begin
          query_head_cnt <= query_head_cnt + 1'b1;
        end
      end else begin
        query_block_cnt <= query_block_cnt + 1'b1;
      end
    end
  end

  // Key stream position, independent of the query side
  always_ff @(posedge clk) begin
    if (rst) begin
      key_block_cnt <= '0;
      key_head_cnt  <= '0;
    end else if (key_fire) begin
      if (key_last_block) begin
        key_block_cnt <= '0;
        if (key_head_cnt == HEAD_W'(NUM_HEADS - 1)) begin
          key_head_cnt <= '0;
        end else begin
          key_head_cnt <= key_head_cnt + 1'b1;
        end
      end else begin
        key_block_cnt <= key_block_cnt + 1'b1;
      end
    end
  end

  // Steer each valid to its current head only
  always_comb begin
    for (int h = 0; h < NUM_HEADS; h++) begin
      split_query_valid[h] = query_valid && (query_head_cnt == HEAD_W'(h));
      split_key_valid[h]   = key_valid && (key_head_cnt == HEAD_W'(h));
    end
  end

  assign query_ready = split_query_ready[query_head_cnt];
  assign key_ready   = split_key_ready[key_head_cnt];

  // Head length must be legal on any block that moves
  a_bph_legal: assert property (
    @(posedge clk) disable iff (rst)
    (query_fire || key_fire) |->
      (block_per_head >= 1 && block_per_head <= BPH_W'(MAX_BLOCK_PER_HEAD))
  );

endmodule

//--- design/head_score_top.sv
module head_score_top (
  input  logic                                clk,
  input  logic                                rst,

  input  logic [attn_pkg::BPH_W-1:0]          block_per_head,

  input  logic                                query_valid,
  output logic                                query_ready,
  input  logic [attn_pkg::BLOCK_W-1:0]        query_data,

  input  logic                                key_valid,
  output logic                                key_ready,
  input  logic [attn_pkg::BLOCK_W-1:0]        key_data,

  output logic                                out_valid,
  input  logic                                out_ready,
  output logic signed [attn_pkg::SCORE_W-1:0] out_score,
  output logic [attn_pkg::HEAD_W-1:0]         out_head
);

  import attn_pkg::*;

  logic [NUM_HEADS-1:0] split_query_valid;
  logic [NUM_HEADS-1:0] split_query_ready;
  logic [NUM_HEADS-1:0] split_key_valid;
  logic [NUM_HEADS-1:0] split_key_ready;

  logic [NUM_HEADS-1:0]              head_score_valid;
  logic [NUM_HEADS-1:0]              head_score_ready;
  logic [NUM_HEADS-1:0][SCORE_W-1:0] head_score;

  head_scatter u_head_scatter (
    .clk               (clk),
    .rst               (rst),
    .block_per_head    (block_per_head),
    .query_valid       (query_valid),
    .query_ready       (query_ready),
    .key_valid         (key_valid),
    .key_ready         (key_ready),
    .split_query_valid (split_query_valid),
    .split_query_ready (split_query_ready),
    .split_key_valid   (split_key_valid),
    .split_key_ready   (split_key_ready)
  );

  // Data is broadcast, the scatter picks the head by valid
  for (genvar h = 0; h < NUM_HEADS; h++) begin : g_head
    head_dot_unit u_head_dot_unit (
      .clk            (clk),
      .rst            (rst),
      .block_per_head (block_per_head),
      .query_valid    (split_query_valid[h]),
      .query_ready    (split_query_ready[h]),
      .query_data     (query_data),
      .key_valid      (split_key_valid[h]),
      .key_ready      (split_key_ready[h]),
      .key_data       (key_data),
      .score_valid    (head_score_valid[h]),
      .score_ready    (head_score_ready[h]),
      .score          (head_score[h])
    );
  end

  score_gather u_score_gather (
    .clk         (clk),
    .rst         (rst),
    .score_valid (head_score_valid),
    .score_ready (head_score_ready),
    .score       (head_score),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_score   (out_score),
    .out_head    (out_head)
  );

endmodule

//--- design/score_gather.sv
module score_gather (
  input  logic                                                  clk,
  input  logic                                                  rst,

  input  logic [attn_pkg::NUM_HEADS-1:0]                        score_valid,
  output logic [attn_pkg::NUM_HEADS-1:0]                        score_ready,
  input  logic [attn_pkg::NUM_HEADS-1:0][attn_pkg::SCORE_W-1:0] score,

  output logic                                                  out_valid,
  input  logic                                                  out_ready,
  output logic signed [attn_pkg::SCORE_W-1:0]                   out_score,
  output logic [attn_pkg::HEAD_W-1:0]                           out_head
);

  import attn_pkg::*;

  logic [HEAD_W-1:0] head_ptr;
  logic              out_fire;

  assign out_fire = out_valid && out_ready;

  // Heads are drained strictly in order
  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
    end else if (out_fire) begin
      if (head_ptr == HEAD_W'(NUM_HEADS - 1)) begin
        head_ptr <= '0;
      end else begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  assign out_valid = score_valid[head_ptr];
  assign out_score = score[head_ptr];
  assign out_head  = head_ptr;

  // Only the selected head sees the downstream ready
  always_comb begin
    for (int h = 0; h < NUM_HEADS; h++) begin
      score_ready[h] = out_ready && (head_ptr == HEAD_W'(h));
    end
  end

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_score) && $stable(out_head))
  );

endmodule

//--- project.f
design/attn_pkg.sv
design/head_scatter.sv
design/head_dot_unit.sv
design/score_gather.sv
design/head_score_top.sv
tests/head_score_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module head_score_tb \
  -o head_score_sim

sim_output=$(./obj_dir/head_score_sim)
echo "$sim_output"

if grep -qx "RESULT: PASS" <<< "$sim_output"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- tests/head_score_tb.sv
module head_score_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import attn_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h26f6_e833;

  // Block pairs over every sequence run below
  localparam int TOTAL_PAIRS = NUM_HEADS * (1 + 8 + 4 + 6 + 3 + 5 + 2);
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_PAIRS + 200;

  localparam int SLOTS = NUM_HEADS * MAX_BLOCK_PER_HEAD;

  logic                       clk = 1'b0;
  logic                       rst;
  logic [BPH_W-1:0]           block_per_head;
  logic                       query_valid;
  logic                       query_ready;
  logic [BLOCK_W-1:0]         query_data;
  logic                       key_valid;
  logic                       key_ready;
  logic [BLOCK_W-1:0]         key_data;
  logic                       out_valid;
  logic                       out_ready;
  logic signed [SCORE_W-1:0]  out_score;
  logic [HEAD_W-1:0]          out_head;

  logic [31:0]        lfsr_state;
  logic [BLOCK_W-1:0] q_blk [SLOTS];
  logic [BLOCK_W-1:0] k_blk [SLOTS];
  int                 q_gap [SLOTS];
  int                 k_gap [SLOTS];

  longint exp_score [$];
  int     exp_head [$];
  string  cur_test;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;

  head_score_top u_head_score_top (
    .clk            (clk),
    .rst            (rst),
    .block_per_head (block_per_head),
    .query_valid    (query_valid),
    .query_ready    (query_ready),
    .query_data     (query_data),
    .key_valid      (key_valid),
    .key_ready      (key_ready),
    .key_data       (key_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .out_score      (out_score),
    .out_head       (out_head)
  );

  always #5 clk = ~clk;

  // Fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Signed dot product over all blocks of one head
  function automatic longint ref_score(input int head, input int bph);
    longint                   sum;
    logic signed [ELEM_W-1:0] qe;
    logic signed [ELEM_W-1:0] ke;
    int                       idx;
    sum = 0;
    for (int b = 0; b < bph; b++) begin
      idx = head * MAX_BLOCK_PER_HEAD + b;
      for (int l = 0; l < LANES; l++) begin
        qe = q_blk[idx][l*ELEM_W +: ELEM_W];
        ke = k_blk[idx][l*ELEM_W +: ELEM_W];
        sum = sum + longint'(qe) * longint'(ke);
      end
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input longint expected, input longint actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("ERROR %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic send_query(input int bph);
    int idx;
    for (int h = 0; h < NUM_HEADS; h++) begin
      for (int b = 0; b < bph; b++) begin
        idx = h * MAX_BLOCK_PER_HEAD + b;
        if (q_gap[idx] > 0) begin
          query_valid = 1'b0;
          repeat (q_gap[idx]) @(negedge clk);
        end
        query_valid = 1'b1;
        query_data  = q_blk[idx];
        @(posedge clk);
        while (!query_ready) @(posedge clk);
        @(negedge clk);
      end
    end
    query_valid = 1'b0;
  endtask

  task automatic send_key(input int bph);
    int idx;
    for (int h = 0; h < NUM_HEADS; h++) begin
      for (int b = 0; b < bph; b++) begin
        idx = h * MAX_BLOCK_PER_HEAD + b;
        if (k_gap[idx] > 0) begin
          key_valid = 1'b0;
          repeat (k_gap[idx]) @(negedge clk);
        end
        key_valid = 1'b1;
        key_data  = k_blk[idx];
        @(posedge clk);
        while (!key_ready) @(posedge clk);
        @(negedge clk);
      end
    end
    key_valid = 1'b0;
  endtask

  // Runs until every expected score has been taken
  task automatic drive_out_ready(input bit stall);
    logic [31:0] stall_bit;
    while (exp_score.size() != 0) begin
      if (stall) begin
        stall_bit = take_bits(1);
        out_ready = stall_bit[0];
      end else begin
        out_ready = 1'b1;
      end
      @(negedge clk);
    end
    out_ready = 1'b1;
  endtask

  // Called on a falling edge with the unit idle
  task automatic run_sequence(input string name, input int bph, input int q_gap_bits,
                              input int k_gap_bits, input bit stall);
    int idx;
    cur_test = name;
    block_per_head = BPH_W'(bph);
    for (int h = 0; h < NUM_HEADS; h++) begin
      for (int b = 0; b < bph; b++) begin
        idx = h * MAX_BLOCK_PER_HEAD + b;
        q_blk[idx] = take_bits(BLOCK_W);
        k_blk[idx] = take_bits(BLOCK_W);
        q_gap[idx] = int'(take_bits(q_gap_bits));
        k_gap[idx] = int'(take_bits(k_gap_bits));
      end
      exp_score.push_back(ref_score(h, bph));
      exp_head.push_back(h);
    end
    fork
      send_query(bph);
      send_key(bph);
      drive_out_ready(stall);
    join
  endtask

  // Every out transfer is matched against the next expected head
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_score.size() == 0) begin
        error_count++;
        $display("Score for head %0d arrived in %s when none was expected", out_head,
                 cur_test);
      end else begin
        check_value({cur_test, " head"}, longint'(exp_head.pop_front()), longint'(out_head));
        check_value({cur_test, " score"}, exp_score.pop_front(), longint'(out_score));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout in %s after %0d cycles with %0d scores still missing", cur_test,
               cycle_count, exp_score.size());
      $display("Errors: %0d  Checks: %0d", error_count, check_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    lfsr_state     = LFSR_SEED;
    cur_test       = "reset";
    rst            = 1'b1;
    block_per_head = BPH_W'(1);
    query_valid    = 1'b0;
    query_data     = '0;
    key_valid      = 1'b0;
    key_data       = '0;
    out_ready      = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    run_sequence("bph1_basic", 1, 0, 0, 1'b0);
    run_sequence("bph8_signed", 8, 1, 1, 1'b0);
    run_sequence("out_stall", 4, 2, 2, 1'b1);
    run_sequence("key_lag", 6, 0, 3, 1'b0);
    run_sequence("seq_bph3", 3, 1, 1, 1'b0);
    run_sequence("seq_bph5", 5, 1, 1, 1'b1);
    run_sequence("seq_bph2", 2, 1, 1, 1'b0);

    // Idle a while so a duplicate score would still be caught
    repeat (20) @(negedge clk);

    $display("Errors: %0d  Checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
